/* all.f */
source/muldiv_cfg_pkg.sv
source/muldiv_op_pkg.sv
source/muldiv_ifs.sv
source/muldiv_issue.sv
source/muldiv_fsm.sv
source/booth_mul_engine.sv
source/nonrestoring_div_engine.sv
source/shared_datapath.sv
source/muldiv_top.sv
verif/muldiv_checker.sv
verif/tb_muldiv.sv

/* run.sh */
#!/bin/sh
# Compile and run the multiply/divide testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_muldiv -f all.f \
  -o sim_muldiv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_muldiv > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$SIM_LOG"; then
  exit 1
fi
exit 0

/* verif/tb_muldiv.sv */
// Testbench top with clock, reset, stimulus table with expected values and the driving loop
`timescale 1ns/1ps

module tb_muldiv import muldiv_op_pkg::*; ();

  localparam int NUM_DIR    = 24;
  localparam int NUM_RAND   = 32;
  localparam int NUM        = NUM_DIR + NUM_RAND;
  localparam int WAIT_LIMIT = 100;

  logic         clk;
  logic         arst_n;
  logic         req_valid;
  logic         req_ready;
  muldiv_op_e   req_op;
  logic [31:0]  req_rs1;
  logic [31:0]  req_rs2;
  logic         rsp_valid;
  logic         rsp_ready;
  logic [31:0]  rsp_result;
  logic [127:0] exp_name;
  logic [31:0]  exp_value;
  int           exp_lat;
  int           tests;
  int           errors;
  int           corr;
  int           wait_cyc;
  int           n_entries;
  int           seed_ret;
  logic         timed_out;

  // Stimulus table
  logic [127:0] tbl_name [NUM];
  muldiv_op_e   tbl_op   [NUM];
  logic [31:0]  tbl_rs1  [NUM];
  logic [31:0]  tbl_rs2  [NUM];
  logic [31:0]  tbl_exp  [NUM];

  muldiv_top dut0 (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_req_valid  (req_valid),
    .o_req_ready  (req_ready),
    .i_req_op     (req_op),
    .i_req_rs1    (req_rs1),
    .i_req_rs2    (req_rs2),
    .o_rsp_valid  (rsp_valid),
    .i_rsp_ready  (rsp_ready),
    .o_rsp_result (rsp_result)
  );

  muldiv_checker u_checker (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_req_valid  (req_valid),
    .i_req_ready  (req_ready),
    .i_rsp_valid  (rsp_valid),
    .i_rsp_ready  (rsp_ready),
    .i_rsp_result (rsp_result),
    .i_exp_name   (exp_name),
    .i_exp_value  (exp_value),
    .i_exp_lat    (exp_lat),
    .o_tests      (tests),
    .o_errors     (errors),
    .o_corr       (corr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Expected values from the M-extension rules

  function automatic logic [31:0] ref_result(muldiv_op_e f_op, logic [31:0] a, logic [31:0] b);
    logic               a_s;
    logic               b_s;
    logic               ovf;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] quot;
    logic signed [31:0] remd;
    logic [63:0]        prod;
    logic [31:0]        res;
    // Sign-extended 64-bit product, low 64 bits are exact
    a_s  = a[31] & (f_op != OP_MULHU);
    b_s  = b[31] & ((f_op == OP_MUL) || (f_op == OP_MULH));
    prod = {{32{a_s}}, a} * {{32{b_s}}, b};
    // Signed quotient and remainder, only where the ISA gives no fixed result
    sa   = a;
    sb   = b;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    if ((b != 32'd0) && !ovf) begin
      quot = sa / sb;
      remd = sa % sb;
    end else begin
      quot = 32'sd0;
      remd = 32'sd0;
    end
    case (f_op)
      OP_MUL:  res = prod[31:0];
      OP_DIV:  res = (b == 32'd0) ? 32'hffff_ffff : (ovf ? 32'h8000_0000 : quot);
      OP_REM:  res = (b == 32'd0) ? a : (ovf ? 32'd0 : remd);
      OP_DIVU: res = (b == 32'd0) ? 32'hffff_ffff : a / b;
      OP_REMU: res = (b == 32'd0) ? a : a % b;
      default: res = prod[63:32];
    endcase
    return res;
  endfunction

  // Cycles from accept to valid, 0 stands for the divide's 35 or 37
  function automatic int latency_of(muldiv_op_e f_op, logic [31:0] a, logic [31:0] b);
    if (!f_op[2]) return 18;
    if (b == 32'd0) return 1;
    if (((f_op == OP_DIV) || (f_op == OP_REM)) && (a == 32'h8000_0000) && (&b)) return 1;
    return 0;
  endfunction

  task automatic add_entry(input logic [127:0] nm, input muldiv_op_e t_op,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] expv);
    tbl_name[n_entries] = nm;
    tbl_op[n_entries]   = t_op;
    tbl_rs1[n_entries]  = a;
    tbl_rs2[n_entries]  = b;
    tbl_exp[n_entries]  = expv;
    n_entries++;
  endtask

  task automatic fill_table();
    logic [127:0] r_name;
    muldiv_op_e   r_op;
    logic [31:0]  r_a;
    logic [31:0]  r_b;
    // Multiplies, hand-computed
    add_entry("mul_small", OP_MUL, 32'd7, 32'd6, 32'h0000_002a);
    add_entry("mul_neg", OP_MUL, 32'hffff_fffd, 32'd5, 32'hffff_fff1);
    add_entry("mul_umax", OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
    add_entry("mulh_neg", OP_MULH, 32'hffff_fffd, 32'd5, 32'hffff_ffff);
    add_entry("mulh_min_min", OP_MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_entry("mulh_min_max", OP_MULH, 32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000);
    add_entry("mulhsu_neg", OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
    add_entry("mulhsu_pos", OP_MULHSU, 32'd2, 32'h8000_0000, 32'h0000_0001);
    add_entry("mulhu_umax", OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
    add_entry("mulhu_small", OP_MULHU, 32'h1234_5678, 32'h0000_0010, 32'h0000_0001);
    // Divides, mixed signs and exact quotients for the correction path
    add_entry("div_pos", OP_DIV, 32'd20, 32'd6, 32'd3);
    add_entry("div_neg_pos", OP_DIV, 32'hffff_fff9, 32'd2, 32'hffff_fffd);
    add_entry("rem_neg_pos", OP_REM, 32'hffff_fff9, 32'd2, 32'hffff_ffff);
    add_entry("div_pos_neg", OP_DIV, 32'd7, 32'hffff_fffe, 32'hffff_fffd);
    add_entry("rem_pos_neg", OP_REM, 32'd7, 32'hffff_fffe, 32'd1);
    add_entry("div_exact_neg", OP_DIV, 32'hffff_fffa, 32'd3, 32'hffff_fffe);
    add_entry("rem_exact", OP_REM, 32'd6, 32'hffff_fffd, 32'd0);
    add_entry("rem_min_3", OP_REM, 32'h8000_0000, 32'd3, 32'hffff_fffe);
    add_entry("divu_umax", OP_DIVU, 32'hffff_ffff, 32'd2, 32'h7fff_ffff);
    add_entry("remu_min_umax", OP_REMU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    // Fixed results for zero divisor and signed overflow
    add_entry("div_by_zero", OP_DIV, 32'd5, 32'd0, 32'hffff_ffff);
    add_entry("remu_by_zero", OP_REMU, 32'hdead_beef, 32'd0, 32'hdead_beef);
    add_entry("div_overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    add_entry("rem_overflow", OP_REM, 32'h8000_0000, 32'hffff_ffff, 32'd0);
    for (int k = 0; k < NUM_RAND; k++) begin
      r_op = muldiv_op_e'(3'($urandom % 8));
      r_a  = $urandom;
      r_b  = $urandom;
      // Smaller divisors give quotients of useful size, now and then zero
      if ($urandom % 2 == 0) r_b = r_b >> ($urandom % 32);
      if ($urandom % 16 == 0) r_b = 32'd0;
      r_name        = "rnd_00";
      r_name[15:8]  = 8'h30 + 8'(k / 10);
      r_name[7:0]   = 8'h30 + 8'(k % 10);
      add_entry(r_name, r_op, r_a, r_b, ref_result(r_op, r_a, r_b));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driving loop

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_MUL;
    req_rs1   = 32'd0;
    req_rs2   = 32'd0;
    rsp_ready = 1'b0;
    exp_name  = '0;
    exp_value = 32'd0;
    exp_lat   = 0;
    n_entries = 0;
    timed_out = 1'b0;
    seed_ret  = $urandom(32'h986c_e89e);
    fill_table();
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_entries && !timed_out; i++) begin
      @(posedge clk);
      req_valid <= 1'b1;
      req_op    <= tbl_op[i];
      req_rs1   <= tbl_rs1[i];
      req_rs2   <= tbl_rs2[i];
      exp_name  <= tbl_name[i];
      exp_value <= tbl_exp[i];
      exp_lat   <= latency_of(tbl_op[i], tbl_rs1[i], tbl_rs2[i]);
      // Accept is the first edge that samples ready high
      wait_cyc = 0;
      do begin
        @(posedge clk);
        wait_cyc++;
      end while (!req_ready && wait_cyc < WAIT_LIMIT);
      req_valid <= 1'b0;
      if (!req_ready) begin
        $display("Timeout: test %0s was not accepted within %0d cycles", tbl_name[i],
                 WAIT_LIMIT);
        timed_out = 1'b1;
      end else begin
        wait_cyc = 0;
        do begin
          @(posedge clk);
          wait_cyc++;
        end while (!rsp_valid && wait_cyc < WAIT_LIMIT);
        if (!rsp_valid) begin
          $display("Timeout: test %0s gave no response within %0d cycles", tbl_name[i],
                   WAIT_LIMIT);
          timed_out = 1'b1;
        end else begin
          // Stall the response a few cycles before taking it
          repeat ($urandom % 4) @(posedge clk);
          rsp_ready <= 1'b1;
          @(posedge clk);
          rsp_ready <= 1'b0;
        end
      end
    end
    repeat (2) @(posedge clk);
    if (corr == 0) $display("No divide went through the correction path");
    if (!timed_out && tests != n_entries) begin
      $display("Only %0d of %0d tests returned a response", tests, n_entries);
    end
    $display("Summary: %0d of %0d tests done, %0d errors, %0d corrected divides", tests,
             n_entries, errors, corr);
    if (timed_out || errors != 0 || tests != n_entries || corr == 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  end

endmodule

/* verif/muldiv_checker.sv */
// Response checker with accept-to-valid latency, result hold while stalled and value compare
`timescale 1ns/1ps

module muldiv_checker import muldiv_cfg_pkg::*; (
  input  logic            clk,
  input  logic            i_arst_n,
  input  logic            i_req_valid,
  input  logic            i_req_ready,
  input  logic            i_rsp_valid,
  input  logic            i_rsp_ready,
  input  logic [XLEN-1:0] i_rsp_result,
  // Expected values for the request now on the bus
  input  logic [127:0]    i_exp_name,
  input  logic [XLEN-1:0] i_exp_value,
  input  int              i_exp_lat,
  output int              o_tests,
  output int              o_errors,
  output int              o_corr
);

  int              tests = 0;
  int              errors = 0;
  int              corr = 0;
  int              cyc = 0;
  int              lat_r = 0;
  logic            reset_seen = 1'b0;
  logic            busy = 1'b0;
  logic            seen_valid = 1'b0;
  logic            held = 1'b0;
  logic [XLEN-1:0] held_result = '0;
  logic [127:0]    name_r = '0;
  logic [XLEN-1:0] exp_r = '0;

  assign o_tests  = tests;
  assign o_errors = errors;
  assign o_corr   = corr;

  // All ports sampled on the rising edge, before any update of that edge
  always @(posedge clk) begin
    if (i_arst_n) begin
      // Idle handshake state straight out of reset
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (!i_req_ready || i_rsp_valid) begin
          $display("After reset o_req_ready is %0b and o_rsp_valid is %0b", i_req_ready,
                   i_rsp_valid);
          errors++;
        end
      end

      //////////////////////////////////////////////////////////////////////
      // Stalled response, result and valid must hold
      if (held) begin
        if (!i_rsp_valid) begin
          $display("o_rsp_valid dropped before test %0s was taken", name_r);
          errors++;
        end else if (i_rsp_result !== held_result) begin
          $display("o_rsp_result changed while test %0s was waiting", name_r);
          errors++;
        end
      end
      if (i_rsp_valid && !i_rsp_ready && i_req_ready) begin
        $display("o_req_ready is high while test %0s is waiting", name_r);
        errors++;
      end
      held        = i_rsp_valid && !i_rsp_ready;
      held_result = i_rsp_result;

      //////////////////////////////////////////////////////////////////////
      // Latency, first sampled valid edge after the accept
      if (busy && !seen_valid) begin
        if (i_rsp_valid) begin
          seen_valid = 1'b1;
          // 37 cycles means quotient and remainder correction ran
          if (cyc == 37) corr++;
          if (lat_r == 0 && cyc != 35 && cyc != 37) begin
            $display("Test %0s answered after %0d cycles, expected 35 or 37", name_r, cyc);
            errors++;
          end else if (lat_r != 0 && cyc != lat_r) begin
            $display("Test %0s answered after %0d cycles, expected %0d", name_r, cyc, lat_r);
            errors++;
          end
        end else begin
          cyc++;
        end
      end

      // Response handshake ends the test
      if (i_rsp_valid && i_rsp_ready) begin
        if (!busy) begin
          $display("Response handshake with no request in flight");
          errors++;
        end else begin
          tests++;
          if (i_rsp_result !== exp_r) begin
            $display("Mismatch in test %0s: expected %h, actual %h", name_r, exp_r,
                     i_rsp_result);
            errors++;
          end else begin
            $display("Test %0s passed with %h", name_r, i_rsp_result);
          end
        end
        busy = 1'b0;
      end

      // Request handshake, take this test's expectations
      if (i_req_valid && i_req_ready) begin
        name_r     = i_exp_name;
        exp_r      = i_exp_value;
        lat_r      = i_exp_lat;
        busy       = 1'b1;
        seen_valid = 1'b0;
        cyc        = 0;
      end
    end
  end

endmodule

/* source/muldiv_top.sv */
// Multiply/divide unit top level with its interface and block instances
`timescale 1ns/1ps

module muldiv_top import muldiv_cfg_pkg::*, muldiv_op_pkg::*; (
  input  logic            clk,
  input  logic            i_arst_n,
  // Request side
  input  logic            i_req_valid,
  output logic            o_req_ready,
  input  muldiv_op_e      i_req_op,
  input  logic [XLEN-1:0] i_req_rs1,
  input  logic [XLEN-1:0] i_req_rs2,
  // Response side
  output logic            o_rsp_valid,
  input  logic            i_rsp_ready,
  output logic [XLEN-1:0] o_rsp_result
);

  logic accept;
  logic done_load;

  muldiv_op_if    op_if ();
  muldiv_phase_if phase_if ();
  // One adder request per engine
  shared_dp_if    mul_dp_if ();
  shared_dp_if    div_dp_if ();

  muldiv_issue u_issue (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req_op     (i_req_op),
    .i_req_rs1    (i_req_rs1),
    .i_req_rs2    (i_req_rs2),
    .i_accept     (accept),
    .i_done_load  (done_load),
    .o_rsp_result (o_rsp_result),
    .op           (op_if.drv),
    .phase        (phase_if.rd),
    .mul_dp       (mul_dp_if.rd),
    .div_dp       (div_dp_if.rd)
  );

  muldiv_fsm u_fsm (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_accept    (accept),
    .o_done_load (done_load),
    .op          (op_if.rd),
    .phase       (phase_if.fsm)
  );

  booth_mul_engine u_mul (
    .op    (op_if.rd),
    .phase (phase_if.rd),
    .dp    (mul_dp_if.eng)
  );

  nonrestoring_div_engine u_div (
    .op    (op_if.rd),
    .phase (phase_if.div),
    .dp    (div_dp_if.eng)
  );

  shared_datapath u_dp (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .op       (op_if.rd),
    .mul_dp   (mul_dp_if.dp),
    .div_dp   (div_dp_if.dp)
  );

endmodule

/* source/shared_datapath.sv */
// Shared adder with its engine request mux and the two partial-result buffers
`timescale 1ns/1ps

module shared_datapath import muldiv_cfg_pkg::*; (
  input  logic    clk,
  input  logic    i_arst_n,
  muldiv_op_if.rd op,
  shared_dp_if.dp mul_dp,
  shared_dp_if.dp div_dp
);

  logic [ADDER_W-1:0] add_op1;
  logic [ADDER_W-1:0] add_op2;
  logic [ADDER_W-1:0] add_sum;
  logic               add_sub;
  logic               buf0_ena;
  logic               buf1_ena;
  logic [BUF_W:0]     buf0_nxt;
  logic [BUF_W:0]     buf1_nxt;
  logic [BUF_W:0]     buf0_r;
  logic [BUF_W:0]     buf1_r;

  // Active engine follows the captured operation family
  assign add_op1  = op.is_div ? div_dp.op1      : mul_dp.op1;
  assign add_op2  = op.is_div ? div_dp.op2      : mul_dp.op2;
  assign add_sub  = op.is_div ? div_dp.sub      : mul_dp.sub;
  assign buf0_ena = op.is_div ? div_dp.buf0_ena : mul_dp.buf0_ena;
  assign buf1_ena = op.is_div ? div_dp.buf1_ena : mul_dp.buf1_ena;
  assign buf0_nxt = op.is_div ? div_dp.buf0_nxt : mul_dp.buf0_nxt;
  assign buf1_nxt = op.is_div ? div_dp.buf1_nxt : mul_dp.buf1_nxt;

  // Subtract is inverted operand plus carry in
  assign add_sum = add_op1 + (add_op2 ^ {ADDER_W{add_sub}}) + ADDER_W'(add_sub);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      buf0_r <= '0;
      buf1_r <= '0;
    end else begin
      if (buf0_ena) begin
        buf0_r <= buf0_nxt;
      end
      if (buf1_ena) begin
        buf1_r <= buf1_nxt;
      end
    end
  end

  // Both engines see the same sum and buffers
  assign mul_dp.res    = add_sum;
  assign div_dp.res    = add_sum;
  assign mul_dp.buf0_r = buf0_r;
  assign div_dp.buf0_r = buf0_r;
  assign mul_dp.buf1_r = buf1_r;
  assign div_dp.buf1_r = buf1_r;

endmodule

/* source/nonrestoring_div_engine.sv */
// Non-restoring divider steps, remainder check and quotient/remainder correction
`timescale 1ns/1ps

module nonrestoring_div_engine import muldiv_cfg_pkg::*, muldiv_op_pkg::*; (
  muldiv_op_if.rd     op,
  muldiv_phase_if.div phase,
  shared_dp_if.eng    dp
);

  logic [DIV_W-1:0] divisor;
  logic [DIV_W-1:0] sum;
  logic [BUF_W-1:0] part_remd;
  logic [BUF_W-1:0] part_quot;
  logic [BUF_W-1:0] quot_low;
  logic             remd_sft1;
  logic             quot_0;
  logic             prev_quot;
  logic             cur_quot;
  logic             remd_is_0;
  logic             remd_is_divs;
  logic             remd_is_neg_divs;
  logic             inc_dec;

  assign divisor   = {op.rs2_sign, op.rs2_sign, op.rs2};
  assign sum       = dp.res[DIV_W-1:0];
  // buf0 is the partial remainder, its top bit the guard bit of the last sum
  assign part_remd = dp.buf0_r[BUF_W-1:0];
  assign remd_sft1 = dp.buf0_r[BUF_W];
  assign part_quot = dp.buf1_r[BUF_W-1:0];

  // First quotient digit is -1 when dividend and divisor signs differ
  assign quot_0    = ~(op.rs1_sign ^ op.rs2_sign);
  assign prev_quot = phase.first ? quot_0 : part_quot[0];
  // Low half of the shifting remainder/quotient pair
  assign quot_low  = phase.first ? {op.rs1, quot_0} : part_quot;
  assign cur_quot  = ~(sum[DIV_W-1] ^ divisor[DIV_W-1]);

  //////////////////////////////////////////////////////////////////////
  // Remainder check and correction direction

  assign remd_is_0        = (part_remd == '0);
  assign remd_is_divs     = (part_remd == divisor[BUF_W-1:0]);
  // REMD_CHCK adds the divisor, so a zero sum means remainder is -divisor
  assign remd_is_neg_divs = (sum == '0);
  assign phase.need_corr  = ((part_remd[BUF_W-1] ^ op.rs1_sign) & ~remd_is_0) |
                            remd_is_divs | remd_is_neg_divs;

  // Remainder and divisor signs differ: remainder up, quotient down
  assign inc_dec = part_remd[BUF_W-1] ^ divisor[DIV_W-1];

  always_comb begin
    dp.op1      = '0;
    dp.op2      = '0;
    dp.sub      = 1'b0;
    dp.buf0_ena = 1'b0;
    dp.buf1_ena = 1'b0;
    dp.buf0_nxt = {sum[BUF_W-1], sum[BUF_W-1:0]};
    dp.buf1_nxt = {1'b0, sum[BUF_W-1:0]};
    case (phase.state)
      ST_EXEC: begin
        // Subtract after a positive digit, add after a negative one
        dp.op1      = ADDER_W'(phase.first ? {DIV_W{op.rs1_sign}} : {remd_sft1, part_remd});
        dp.op2      = ADDER_W'(divisor);
        dp.sub      = prev_quot;
        dp.buf0_ena = 1'b1;
        dp.buf1_ena = 1'b1;
        if (phase.last) begin
          // Final remainder is left unshifted, last digit forced to one
          dp.buf1_nxt = {1'b0, quot_low[XLEN-1:0], 1'b1};
        end else begin
          dp.buf0_nxt = {sum[BUF_W-1:0], quot_low[BUF_W-1]};
          dp.buf1_nxt = {1'b0, quot_low[XLEN-1:0], cur_quot};
        end
      end
      ST_REMD_CHCK: begin
        dp.op1 = ADDER_W'({part_remd[BUF_W-1], part_remd});
        dp.op2 = ADDER_W'(divisor);
      end
      ST_QUOT_CORR: begin
        dp.op1      = ADDER_W'({part_quot[BUF_W-1], part_quot});
        dp.op2      = ADDER_W'(1);
        dp.sub      = inc_dec;
        dp.buf1_ena = 1'b1;
      end
      ST_REMD_CORR: begin
        dp.op1      = ADDER_W'({part_remd[BUF_W-1], part_remd});
        dp.op2      = ADDER_W'(divisor);
        dp.sub      = ~inc_dec;
        dp.buf0_ena = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* source/booth_mul_engine.sv */
// Radix-4 Booth multiplier step logic on the shared adder
`timescale 1ns/1ps

module booth_mul_engine import muldiv_cfg_pkg::*, muldiv_op_pkg::*; (
  muldiv_op_if.rd    op,
  muldiv_phase_if.rd phase,
  shared_dp_if.eng   dp
);

  logic [BUF_W-1:0]   prdt_hi;
  logic [BUF_W-1:0]   prdt_lo;
  logic               prdt_sft1;
  logic               sign_step;
  logic [2:0]         booth_code;
  logic               sel_zero;
  logic               sel_two;
  logic [ADDER_W-1:0] rs2_x1;
  logic [ADDER_W-1:0] rs2_x2;

  // buf0 holds the high partial product
  // buf1 holds the low product bits and the multiplier still to recode
  assign prdt_hi   = dp.buf0_r[BUF_W-1:0];
  assign prdt_lo   = dp.buf1_r[BUF_W-1:0];
  // Bit shifted out below the low product on the previous step
  assign prdt_sft1 = dp.buf1_r[BUF_W];
  assign sign_step = (phase.step == CNT_W'(MUL_LAST));

  // Group k looks at multiplier bits 2k+1, 2k and 2k-1
  assign booth_code = phase.first ? {op.rs1[1:0], 1'b0} :
                      sign_step   ? {op.rs1_sign, prdt_lo[0], prdt_sft1} :
                                    {prdt_lo[1:0], prdt_sft1};

  // 000 and 111 add nothing, 011 and 100 take twice the multiplicand
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);

  assign rs2_x1 = {{(ADDER_W-XLEN){op.rs2_sign}}, op.rs2};
  assign rs2_x2 = {{(ADDER_W-XLEN-1){op.rs2_sign}}, op.rs2, 1'b0};

  assign dp.op1 = phase.first ? '0 : {{(ADDER_W-BUF_W){prdt_hi[BUF_W-1]}}, prdt_hi};
  assign dp.op2 = sel_zero ? '0 : (sel_two ? rs2_x2 : rs2_x1);
  // Negative multiples subtract
  assign dp.sub = booth_code[2];

  assign dp.buf0_ena = (phase.state == ST_EXEC);
  assign dp.buf1_ena = (phase.state == ST_EXEC);

  // Two bits per step move from the sum into the low product
  assign dp.buf0_nxt = {dp.res[ADDER_W-1], dp.res[ADDER_W-1:2]};
  assign dp.buf1_nxt = phase.first ?
                       {op.rs1[1], dp.res[1:0], op.rs1_sign, op.rs1[XLEN-1:2]} :
                       {prdt_lo[1], dp.res[1:0], prdt_lo[BUF_W-1:2]};

endmodule

/* source/muldiv_fsm.sv */
// Sequencer FSM, step counter and the request/response handshake
`timescale 1ns/1ps

module muldiv_fsm import muldiv_cfg_pkg::*, muldiv_op_pkg::*; (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic        i_req_valid,
  output logic        o_req_ready,
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready,
  output logic        o_accept,
  output logic        o_done_load,
  muldiv_op_if.rd     op,
  muldiv_phase_if.fsm phase
);

  muldiv_state_e    state_r;
  muldiv_state_e    state_nxt;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W-1:0] cnt_nxt;
  logic             req_rdy_r;
  logic             rsp_hs;
  logic             in_exec;
  logic             last_step;

  // Request side, one item in flight
  assign o_accept    = i_req_valid & req_rdy_r;
  assign o_req_ready = req_rdy_r;
  assign o_rsp_valid = (state_r == ST_DONE);
  assign rsp_hs      = o_rsp_valid & i_rsp_ready;

  assign in_exec   = (state_r == ST_EXEC);
  // Step 16 ends a multiply, step 32 a divide
  assign last_step = in_exec &
                     (cnt_r == (op.is_div ? CNT_W'(DIV_LAST) : CNT_W'(MUL_LAST)));

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        // Ready low in IDLE means a request was just captured
        if (!req_rdy_r) begin
          state_nxt = op.special ? ST_DONE : ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (last_step) begin
          state_nxt = op.is_div ? ST_REMD_CHCK : ST_DONE;
        end
      end
      ST_REMD_CHCK: state_nxt = phase.need_corr ? ST_QUOT_CORR : ST_DONE;
      ST_QUOT_CORR: state_nxt = ST_REMD_CORR;
      ST_REMD_CORR: state_nxt = ST_DONE;
      ST_DONE: begin
        if (rsp_hs) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // Counter runs only in EXEC, back at zero everywhere else
  assign cnt_nxt = (in_exec & ~last_step) ? cnt_r + CNT_W'(1) : '0;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_r   <= ST_IDLE;
      cnt_r     <= '0;
      req_rdy_r <= 1'b1;
    end else begin
      state_r <= state_nxt;
      cnt_r   <= cnt_nxt;
      if (rsp_hs) begin
        req_rdy_r <= 1'b1;
      end else if (o_accept) begin
        req_rdy_r <= 1'b0;
      end
    end
  end

  // Result register strobe on the edge into DONE
  assign o_done_load = (state_nxt == ST_DONE) & (state_r != ST_DONE);

  assign phase.state = state_r;
  assign phase.step  = cnt_r;
  assign phase.first = in_exec & (cnt_r == '0);
  assign phase.last  = last_step;

endmodule

/* source/muldiv_issue.sv */
// Request capture, operand sign bits, divide special cases and the result register
`timescale 1ns/1ps

module muldiv_issue import muldiv_cfg_pkg::*, muldiv_op_pkg::*; (
  input  logic            clk,
  input  logic            i_arst_n,
  input  muldiv_op_e      i_req_op,
  input  logic [XLEN-1:0] i_req_rs1,
  input  logic [XLEN-1:0] i_req_rs2,
  input  logic            i_accept,
  input  logic            i_done_load,
  output logic [XLEN-1:0] o_rsp_result,
  muldiv_op_if.drv        op,
  muldiv_phase_if.rd      phase,
  shared_dp_if.rd         mul_dp,
  shared_dp_if.rd         div_dp
);

  logic            is_quot;
  logic            div_by_0;
  logic            div_ovf;
  logic [XLEN-1:0] special_res;
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] div_remd;
  logic [XLEN-1:0] div_res;

  // Operation steers the datapath mux, so it comes out of reset known
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      op.op <= OP_MUL;
    end else if (i_accept) begin
      op.op <= i_req_op;
    end
  end

  always_ff @(posedge clk) begin
    if (i_accept) begin
      op.rs1 <= i_req_rs1;
      op.rs2 <= i_req_rs2;
    end
  end

  assign op.is_div = op.op[2];

  // Sign extension of each operand to 33 bits
  always_comb begin
    op.rs1_sign = op.rs1[XLEN-1];
    op.rs2_sign = op.rs2[XLEN-1];
    case (op.op)
      OP_MULHSU: op.rs2_sign = 1'b0;
      OP_MULHU, OP_DIVU, OP_REMU: begin
        op.rs1_sign = 1'b0;
        op.rs2_sign = 1'b0;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Special cases, fixed results set by the ISA

  assign is_quot  = (op.op == OP_DIV) | (op.op == OP_DIVU);
  assign div_by_0 = (op.rs2 == '0);
  // Most negative dividend over minus one
  assign div_ovf  = ((op.op == OP_DIV) | (op.op == OP_REM)) & (&op.rs2) &
                    (op.rs1 == {1'b1, {(XLEN-1){1'b0}}});
  assign op.special = op.is_div & (div_by_0 | div_ovf);

  always_comb begin
    if (div_by_0) begin
      special_res = is_quot ? '1 : op.rs1;
    end else begin
      special_res = is_quot ? {1'b1, {(XLEN-1){1'b0}}} : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select, sampled on the edge into DONE

  // Low word sits in the product buffer, high word is the last adder sum
  assign mul_res  = (op.op == OP_MUL) ? mul_dp.buf1_r[XLEN:1] : mul_dp.res[XLEN-1:0];
  // Corrected remainder taken straight off the adder
  assign div_remd = (phase.state == ST_REMD_CORR) ? div_dp.res[XLEN-1:0]
                                                  : div_dp.buf0_r[XLEN-1:0];
  assign div_res  = is_quot ? div_dp.buf1_r[XLEN-1:0] : div_remd;

  always_ff @(posedge clk) begin
    if (i_done_load) begin
      o_rsp_result <= op.special ? special_res : (op.is_div ? div_res : mul_res);
    end
  end

endmodule

/* source/muldiv_ifs.sv */
// Operand, phase and shared-datapath interfaces with their modports
`timescale 1ns/1ps

// Captured request and the flags derived from it
interface muldiv_op_if import muldiv_cfg_pkg::*, muldiv_op_pkg::*; ();
  muldiv_op_e      op;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  // Extension bits, zero for the unsigned operand forms
  logic            rs1_sign;
  logic            rs2_sign;
  logic            is_div;
  // Divide by zero or signed overflow
  logic            special;

  modport drv (output op, rs1, rs2, rs1_sign, rs2_sign, is_div, special);
  modport rd  (input  op, rs1, rs2, rs1_sign, rs2_sign, is_div, special);
endinterface

// Sequencer phase shared by the engines
interface muldiv_phase_if import muldiv_cfg_pkg::*, muldiv_op_pkg::*; ();
  muldiv_state_e    state;
  logic [CNT_W-1:0] step;
  logic             first;
  logic             last;
  // Returned by the divide engine in REMD_CHCK
  logic             need_corr;

  modport fsm (output state, step, first, last, input need_corr);
  modport rd  (input  state, step, first, last);
  modport div (input  state, step, first, last, output need_corr);
endinterface

// One engine's adder request and its view of the partial-result buffers
interface shared_dp_if import muldiv_cfg_pkg::*; ();
  logic [ADDER_W-1:0] op1;
  logic [ADDER_W-1:0] op2;
  logic               sub;
  logic               buf0_ena;
  logic [BUF_W:0]     buf0_nxt;
  logic               buf1_ena;
  logic [BUF_W:0]     buf1_nxt;
  logic [ADDER_W-1:0] res;
  logic [BUF_W:0]     buf0_r;
  logic [BUF_W:0]     buf1_r;

  modport eng (output op1, op2, sub, buf0_ena, buf0_nxt, buf1_ena, buf1_nxt,
               input  res, buf0_r, buf1_r);
  modport dp  (input  op1, op2, sub, buf0_ena, buf0_nxt, buf1_ena, buf1_nxt,
               output res, buf0_r, buf1_r);
  modport rd  (input  res, buf0_r, buf1_r);
endinterface

/* source/muldiv_op_pkg.sv */
// Operation codes and FSM state encoding of the multiply/divide unit
package muldiv_op_pkg;

  // M-extension operations
  // bit 2 set selects the divide family
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_e;

  // Sequencer states
  // IDLE also covers the one start cycle after an accept
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_EXEC      = 3'd1,
    // Divide only, sign and range check of the remainder
    ST_REMD_CHCK = 3'd2,
    ST_QUOT_CORR = 3'd3,
    ST_REMD_CORR = 3'd4,
    // Result held until the response handshake
    ST_DONE      = 3'd5
  } muldiv_state_e;

endpackage

/* source/muldiv_cfg_pkg.sv */
// Width, adder and step-count constants of the multiply/divide unit
package muldiv_cfg_pkg;

  // Operand width of the RV32 integer registers
  localparam int XLEN     = 32;

  // Shared adder, sign plus the 2x Booth multiple of a 33-bit operand
  localparam int ADDER_W  = 35;
  // Divide field, 33-bit partial remainder plus one guard bit
  localparam int DIV_W    = 34;

  // Partial-result width
  // each buffer register holds one extra bit above this
  localparam int BUF_W    = 33;

  // Step counter, large enough for the divide
  localparam int CNT_W    = 6;
  localparam int MUL_LAST = 16;
  localparam int DIV_LAST = 32;

endpackage
